// ==== dv/cpu_patterns.mem ====
// Columns: opcode_rd_ra_rb_imm_linkpc_nowb_expreg_expdata, all hex.
// nowb = 1 marks an instruction without a writeback pulse.
6_1_0_0_0005_0000_0_1_0005
6_2_0_0_0003_0000_0_2_0003
1_3_1_2_0000_0000_0_3_0008
2_4_3_1_0000_0000_0_4_0003
4_5_3_4_0000_0000_0_5_000B
3_6_5_1_0000_0000_0_6_0001
5_7_1_2_0000_0000_0_7_0028
7_6_2_1_0000_0000_0_6_0001
2_7_0_1_0000_0000_0_7_FFFB
7_6_1_7_0000_0000_0_6_0001
7_6_7_1_0000_0000_0_6_0000
A_4_0_0_0000_1234_0_4_1234
9_0_3_5_0010_0000_1_0_0000
8_1_0_0_0018_0000_0_1_000B
1_2_1_1_0000_0000_0_2_0016
6_3_0_0_00FF_0000_0_3_00FF
9_0_3_4_0003_0000_1_0_0000
8_5_0_0_0002_0000_0_5_1234
4_6_5_2_0000_0000_0_6_1222
0_0_0_0_0000_0000_1_0_0000
B_0_0_0_0000_0000_1_0_0000

// ==== dv/tb_cpu_backend.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_cfg.svh"

module tb_cpu_backend import cpu_pkg::*; ();
    localparam int MAX_PAT    = 64;
    localparam int EXP_STALLS = 2;  // The pattern file holds two load-use pairs.

    // Opcode, rd, ra, rb, imm, link_pc, no-writeback flag, expected register and data.
    logic [71:0] pat [MAX_PAT];

    logic                   i_clk;
    logic                   i_arst_n;
    logic                   i_valid;
    logic                   o_ready;
    opcode_e                i_opcode;
    logic [`CPU_REG_AW-1:0] i_rd;
    logic [`CPU_REG_AW-1:0] i_ra;
    logic [`CPU_REG_AW-1:0] i_rb;
    logic [`CPU_DATA_W-1:0] i_imm;
    logic [`CPU_DATA_W-1:0] i_link_pc;
    logic                   o_wb_valid;
    logic [`CPU_REG_AW-1:0] o_wb_reg;
    logic [`CPU_DATA_W-1:0] o_wb_data;
    logic                   o_halt;

    int          n_pat        = 0;
    int          exp_q[$];              // Pattern indices that expect a writeback.
    int          exp_idx      = 0;
    int          stall_cycles = 0;
    int          cycles       = 0;
    int          cycle_limit  = 1000;
    logic [31:0] rng_state    = 32'd4147;

    cpu_backend UUT (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_valid    (i_valid),
        .o_ready    (o_ready),
        .i_opcode   (i_opcode),
        .i_rd       (i_rd),
        .i_ra       (i_ra),
        .i_rb       (i_rb),
        .i_imm      (i_imm),
        .i_link_pc  (i_link_pc),
        .o_wb_valid (o_wb_valid),
        .o_wb_reg   (o_wb_reg),
        .o_wb_data  (o_wb_data),
        .o_halt     (o_halt)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // ************************************************************************
    // Helpers
    // ************************************************************************
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "Run aborted");
    endtask

    // Offers each pattern in order and holds it until o_ready is seen.
    task automatic drive_program();
        int   idx;
        logic prev_load;
        idx       = 0;
        prev_load = 1'b0;
        while (idx < n_pat) begin
            rng_state = xorshift(rng_state);
            if (!prev_load && (rng_state[1:0] == 2'b00)) begin
                i_valid <= 1'b0;              // Idle gap.
                @(posedge i_clk);
            end else begin
                i_valid   <= 1'b1;
                i_opcode  <= opcode_e'(pat[idx][71:68]);
                i_rd      <= pat[idx][66:64];
                i_ra      <= pat[idx][62:60];
                i_rb      <= pat[idx][58:56];
                i_imm     <= pat[idx][55:40];
                i_link_pc <= pat[idx][39:24];
                @(negedge i_clk);
                while (!o_ready) begin
                    stall_cycles++;
                    @(negedge i_clk);
                end
                prev_load = (pat[idx][71:68] == OP_LOAD);  // Next user comes at once.
                idx++;
                @(posedge i_clk);
            end
        end
        i_valid <= 1'b0;
    endtask

    // ************************************************************************
    // Monitor and timeout
    // ************************************************************************
    always @(negedge i_clk) begin
        if (i_arst_n && o_wb_valid) begin
            if (exp_idx >= exp_q.size()) begin
                abort_run("Writeback pulse seen with no expected result left");
            end else begin
                check(32'(o_wb_reg), 32'(pat[exp_q[exp_idx]][18:16]), "writeback register");
                check(32'(o_wb_data), 32'(pat[exp_q[exp_idx]][15:0]), "writeback data");
                exp_idx++;
            end
        end
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            abort_run("Timeout, the run did not finish within the cycle limit");
        end
    end

    // ************************************************************************
    // Main sequence
    // ************************************************************************
    initial begin
        i_arst_n  = 1'b0;
        i_valid   = 1'b0;
        i_opcode  = OP_NOP;
        i_rd      = '0;
        i_ra      = '0;
        i_rb      = '0;
        i_imm     = '0;
        i_link_pc = '0;

        $readmemh("dv/cpu_patterns.mem", pat);
        while ((n_pat < MAX_PAT) && (pat[n_pat][71:68] !== OP_HALT)) begin
            n_pat++;
        end
        if (n_pat == MAX_PAT) begin
            abort_run("The pattern file holds no HALT instruction");
        end else begin
            n_pat++;
            for (int i = 0; i < n_pat; i++) begin
                if (pat[i][23:20] == 4'h0) begin
                    exp_q.push_back(i);
                end
            end
            cycle_limit = 8 * n_pat + 200;

            repeat (16) @(posedge i_clk);
            i_arst_n <= 1'b1;
            drive_program();

            // HALT was only just accepted and cannot have reached writeback.
            @(negedge i_clk);
            check(32'(o_halt), 32'd0, "o_halt before HALT retires");
            while (!o_halt) begin
                @(negedge i_clk);
            end
            // Pipeline must stay quiet and closed once halted.
            repeat (8) begin
                @(negedge i_clk);
                check(32'(o_halt), 32'd1, "o_halt");
                check(32'(o_ready), 32'd0, "o_ready");
            end
            check(32'(exp_idx), 32'(exp_q.size()), "writeback count");
            check(32'(stall_cycles), 32'(EXP_STALLS), "load-use stall cycles");

            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/cpu_pkg.sv
source/stage_if.sv
source/reg_file.sv
source/execute.sv
source/flop_ex2mem.sv
source/mem_stage.sv
source/cpu_backend.sv
dv/tb_cpu_backend.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
    --top-module tb_cpu_backend -f project.f -o tb_cpu_backend

# The testbench exits nonzero on a fatal stop, the log is judged below.
./obj_dir/tb_cpu_backend > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    echo "Simulation FAILED, no final report"
    exit 1
fi
echo "Simulation passed"

// ==== source/cpu_backend.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_cfg.svh"

module cpu_backend import cpu_pkg::*; (
    input  wire                    i_clk,
    input  wire                    i_arst_n,
    // Decoded instruction input.
    input  wire                    i_valid,
    output logic                   o_ready,
    input  var opcode_e            i_opcode,
    input  wire  [`CPU_REG_AW-1:0] i_rd,
    input  wire  [`CPU_REG_AW-1:0] i_ra,
    input  wire  [`CPU_REG_AW-1:0] i_rb,
    input  wire  [`CPU_DATA_W-1:0] i_imm,
    input  wire  [`CPU_DATA_W-1:0] i_link_pc,
    // Writeback report.
    output logic                   o_wb_valid,
    output logic [`CPU_REG_AW-1:0] o_wb_reg,
    output logic [`CPU_DATA_W-1:0] o_wb_data,
    output logic                   o_halt
);
    logic [`CPU_REG_AW-1:0] ra_addr;
    logic [`CPU_REG_AW-1:0] rb_addr;
    logic [`CPU_DATA_W-1:0] ra_data;
    logic [`CPU_DATA_W-1:0] rb_data;

    ex_mem_if ex_to_flop  ();
    ex_mem_if flop_to_mem ();
    mem_wb_if mem_to_wb   ();

    reg_file u_reg_file (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_ra_addr (ra_addr),
        .i_rb_addr (rb_addr),
        .o_ra_data (ra_data),
        .o_rb_data (rb_data),
        .wb        (mem_to_wb.sink)
    );

    execute u_execute (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_valid   (i_valid),
        .o_ready   (o_ready),
        .i_opcode  (i_opcode),
        .i_rd      (i_rd),
        .i_ra      (i_ra),
        .i_rb      (i_rb),
        .i_imm     (i_imm),
        .i_link_pc (i_link_pc),
        .i_ra_data (ra_data),
        .i_rb_data (rb_data),
        .o_ra_addr (ra_addr),
        .o_rb_addr (rb_addr),
        .ex_out    (ex_to_flop.ex),
        .mem_fwd   (flop_to_mem.mem),
        .wb_fwd    (mem_to_wb.monitor)
    );

    // Only bubbles remain behind a halt, so the stage is frozen then.
    flop_ex2mem u_flop_ex2mem (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_hold   (o_halt),
        .d        (ex_to_flop.mem),
        .q        (flop_to_mem.ex)
    );

    mem_stage u_mem_stage (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .m        (flop_to_mem.mem),
        .wb       (mem_to_wb.source)
    );

    assign o_wb_valid = mem_to_wb.valid && mem_to_wb.rf_wen;
    assign o_wb_reg   = mem_to_wb.rO;
    assign o_wb_data  = mem_to_wb.wb_data;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_halt <= 1'b0;
        end else if (mem_to_wb.valid && mem_to_wb.halt) begin
            o_halt <= 1'b1;  // Sticky.
        end
    end

endmodule

`default_nettype wire

// ==== source/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// ************************************************************************
// Datapath sizes
// ************************************************************************

// Data word. Also the width of addresses and link values.
`define CPU_DATA_W 16

// Register index for eight registers.
`define CPU_REG_AW 3

// Data RAM word address. Upper address bits are ignored, so addresses wrap.
`define CPU_DMEM_AW 8

`endif

// ==== source/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // Decoded instruction opcodes.
    typedef enum logic [3:0] {
        OP_NOP   = 4'h0,
        OP_ADD   = 4'h1,
        OP_SUB   = 4'h2,
        OP_AND   = 4'h3,
        OP_XOR   = 4'h4,
        OP_SHL   = 4'h5,  // rA << rB[3:0].
        OP_ADDI  = 4'h6,
        OP_CMPLT = 4'h7,  // Unsigned compare.
        OP_LOAD  = 4'h8,
        OP_STORE = 4'h9,
        OP_LINK  = 4'hA,
        OP_HALT  = 4'hB
    } opcode_e;

    // Writeback source select.
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LINK = 2'd2,
        WB_FLAG = 2'd3
    } wb_op_e;

endpackage

`default_nettype wire

// ==== source/execute.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_cfg.svh"

module execute import cpu_pkg::*; (
    input  wire                    i_clk,
    input  wire                    i_arst_n,
    input  wire                    i_valid,
    output logic                   o_ready,
    input  var opcode_e            i_opcode,
    input  wire  [`CPU_REG_AW-1:0] i_rd,
    input  wire  [`CPU_REG_AW-1:0] i_ra,
    input  wire  [`CPU_REG_AW-1:0] i_rb,
    input  wire  [`CPU_DATA_W-1:0] i_imm,
    input  wire  [`CPU_DATA_W-1:0] i_link_pc,
    input  wire  [`CPU_DATA_W-1:0] i_ra_data,
    input  wire  [`CPU_DATA_W-1:0] i_rb_data,
    output logic [`CPU_REG_AW-1:0] o_ra_addr,
    output logic [`CPU_REG_AW-1:0] o_rb_addr,
    ex_mem_if.ex                   ex_out,
    ex_mem_if.mem                  mem_fwd,
    mem_wb_if.monitor              wb_fwd
);
    logic                   halted;
    logic                   accept;
    logic                   load_use;
    logic                   reads_ra;
    logic                   reads_rb;
    logic                   mem_fwd_ok;
    logic                   wb_fwd_ok;
    logic [`CPU_DATA_W-1:0] mem_val;
    logic [`CPU_DATA_W-1:0] op_a;
    logic [`CPU_DATA_W-1:0] op_b;

    assign o_ra_addr = i_ra;
    assign o_rb_addr = i_rb;

    assign reads_ra = i_opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_SHL,
                                       OP_ADDI, OP_CMPLT, OP_LOAD, OP_STORE};
    assign reads_rb = i_opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_SHL,
                                       OP_CMPLT, OP_STORE};

    // ************************************************************************
    // Issue control
    // ************************************************************************
    assign load_use = mem_fwd.valid && mem_fwd.dmem_ren &&
                      ((reads_ra && (mem_fwd.rO == i_ra)) ||
                       (reads_rb && (mem_fwd.rO == i_rb)));

    assign o_ready = !halted && !load_use;
    assign accept  = i_valid && o_ready;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            halted <= 1'b0;
        end else if (accept && (i_opcode == OP_HALT)) begin
            halted <= 1'b1;  // Nothing is accepted after this.
        end
    end

    // ************************************************************************
    // Operand forwarding
    // ************************************************************************
    always_comb begin
        case (mem_fwd.wb_op)
            WB_LINK: mem_val = mem_fwd.link_pc;
            WB_FLAG: mem_val = {{(`CPU_DATA_W-1){1'b0}}, mem_fwd.flag};
            default: mem_val = mem_fwd.alu_out;
        endcase
    end

    // Load data is not ready yet in the memory stage.
    assign mem_fwd_ok = mem_fwd.valid && mem_fwd.rf_wen && (mem_fwd.wb_op != WB_MEM);
    assign wb_fwd_ok  = wb_fwd.valid && wb_fwd.rf_wen;

    assign op_a = (mem_fwd_ok && (mem_fwd.rO == i_ra)) ? mem_val :
                  (wb_fwd_ok  && (wb_fwd.rO == i_ra))  ? wb_fwd.wb_data : i_ra_data;
    assign op_b = (mem_fwd_ok && (mem_fwd.rO == i_rb)) ? mem_val :
                  (wb_fwd_ok  && (wb_fwd.rO == i_rb))  ? wb_fwd.wb_data : i_rb_data;

    // ************************************************************************
    // ALU and decode
    // ************************************************************************
    always_comb begin
        ex_out.alu_out = '0;
        ex_out.flag    = 1'b0;
        ex_out.wb_op   = WB_ALU;
        case (i_opcode)
            OP_ADD:   ex_out.alu_out = op_a + op_b;
            OP_SUB:   ex_out.alu_out = op_a - op_b;
            OP_AND:   ex_out.alu_out = op_a & op_b;
            OP_XOR:   ex_out.alu_out = op_a ^ op_b;
            OP_SHL:   ex_out.alu_out = op_a << op_b[3:0];
            OP_ADDI,
            OP_STORE: ex_out.alu_out = op_a + i_imm;
            OP_LOAD: begin
                ex_out.alu_out = op_a + i_imm;
                ex_out.wb_op   = WB_MEM;
            end
            OP_CMPLT: begin
                ex_out.flag  = op_a < op_b;
                ex_out.wb_op = WB_FLAG;
            end
            OP_LINK:  ex_out.wb_op = WB_LINK;
            default:  ;
        endcase
    end

    // Bubble whenever nothing is accepted.
    assign ex_out.valid    = accept;
    assign ex_out.halt     = accept && (i_opcode == OP_HALT);
    assign ex_out.rf_wen   = accept && (i_opcode inside {OP_ADD, OP_SUB, OP_AND, OP_XOR,
                                                         OP_SHL, OP_ADDI, OP_CMPLT,
                                                         OP_LOAD, OP_LINK});
    assign ex_out.dmem_ren = accept && (i_opcode == OP_LOAD);
    assign ex_out.dmem_wen = accept && (i_opcode == OP_STORE);
    assign ex_out.rO       = i_rd;
    assign ex_out.link_pc  = i_link_pc;
    assign ex_out.rY       = i_rb;
    assign ex_out.vY       = op_b;  // Forwarded store data.

endmodule

`default_nettype wire

// ==== source/flop_ex2mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module flop_ex2mem (
    input  wire   i_clk,
    input  wire   i_arst_n,
    input  wire   i_hold,
    ex_mem_if.mem d,    // Execute side.
    ex_mem_if.ex  q     // Memory side.
);

    // ************************************************************************
    // Control, cleared by reset
    // ************************************************************************
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            q.valid    <= 1'b0;
            q.halt     <= 1'b0;
            q.rf_wen   <= 1'b0;
            q.dmem_ren <= 1'b0;
            q.dmem_wen <= 1'b0;
        end else if (!i_hold) begin
            q.valid    <= d.valid;
            q.halt     <= d.halt;
            q.rf_wen   <= d.rf_wen;
            q.dmem_ren <= d.dmem_ren;
            q.dmem_wen <= d.dmem_wen;
        end
    end

    // ************************************************************************
    // Payload
    // ************************************************************************
    always_ff @(posedge i_clk) begin
        if (!i_hold) begin
            q.wb_op   <= d.wb_op;
            q.rO      <= d.rO;
            q.alu_out <= d.alu_out;
            q.flag    <= d.flag;
            q.link_pc <= d.link_pc;
            q.rY      <= d.rY;
            q.vY      <= d.vY;
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_stage.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_cfg.svh"

module mem_stage import cpu_pkg::*; (
    input  wire      i_clk,
    input  wire      i_arst_n,
    ex_mem_if.mem    m,
    mem_wb_if.source wb
);
    localparam int DEPTH = 1 << `CPU_DMEM_AW;

    logic [`CPU_DATA_W-1:0]  dmem [DEPTH];
    logic [`CPU_DMEM_AW-1:0] addr;
    logic [`CPU_DATA_W-1:0]  rd_data;
    wb_op_e                  wb_op_q;
    logic [`CPU_DATA_W-1:0]  alu_q;
    logic [`CPU_DATA_W-1:0]  link_q;
    logic                    flag_q;

    assign addr = m.alu_out[`CPU_DMEM_AW-1:0];  // Wraps past the top word.

    // Synchronous data RAM.
    always_ff @(posedge i_clk) begin
        if (m.valid && m.dmem_wen) begin
            dmem[addr] <= m.vY;
        end
        if (m.valid && m.dmem_ren) begin
            rd_data <= dmem[addr];
        end
    end

    // ************************************************************************
    // Memory to writeback register
    // ************************************************************************
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wb.valid  <= 1'b0;
            wb.halt   <= 1'b0;
            wb.rf_wen <= 1'b0;
        end else begin
            wb.valid  <= m.valid;
            wb.halt   <= m.halt;
            wb.rf_wen <= m.rf_wen;
        end
    end

    always_ff @(posedge i_clk) begin
        wb.rO   <= m.rO;
        wb_op_q <= m.wb_op;
        alu_q   <= m.alu_out;
        link_q  <= m.link_pc;
        flag_q  <= m.flag;
    end

    always_comb begin
        case (wb_op_q)
            WB_MEM:  wb.wb_data = rd_data;
            WB_LINK: wb.wb_data = link_q;
            WB_FLAG: wb.wb_data = {{(`CPU_DATA_W-1){1'b0}}, flag_q};
            default: wb.wb_data = alu_q;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_cfg.svh"

module reg_file (
    input  wire                    i_clk,
    input  wire                    i_arst_n,
    input  wire  [`CPU_REG_AW-1:0] i_ra_addr,
    input  wire  [`CPU_REG_AW-1:0] i_rb_addr,
    output logic [`CPU_DATA_W-1:0] o_ra_data,
    output logic [`CPU_DATA_W-1:0] o_rb_data,
    mem_wb_if.sink                 wb
);
    localparam int NREG = 1 << `CPU_REG_AW;

    logic [`CPU_DATA_W-1:0] regs [NREG];
    logic                   wr_en;

    assign wr_en = wb.valid && wb.rf_wen;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rO] <= wb.wb_data;
        end
    end

    // Write-through on both read ports.
    always_comb begin
        o_ra_data = regs[i_ra_addr];
        if (wr_en && (wb.rO == i_ra_addr)) begin
            o_ra_data = wb.wb_data;
        end
    end

    always_comb begin
        o_rb_data = regs[i_rb_addr];
        if (wr_en && (wb.rO == i_rb_addr)) begin
            o_rb_data = wb.wb_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/stage_if.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu_cfg.svh"

// ************************************************************************
// Execute to memory
// ************************************************************************
interface ex_mem_if import cpu_pkg::*; ();
    logic                   valid;
    logic                   halt;
    logic                   rf_wen;
    wb_op_e                 wb_op;
    logic [`CPU_REG_AW-1:0] rO;
    logic [`CPU_DATA_W-1:0] alu_out;   // Also the data memory address.
    logic                   flag;
    logic [`CPU_DATA_W-1:0] link_pc;
    logic [`CPU_REG_AW-1:0] rY;
    logic [`CPU_DATA_W-1:0] vY;        // Store data.
    logic                   dmem_ren;
    logic                   dmem_wen;

    modport ex (output valid, halt, rf_wen, wb_op, rO, alu_out, flag,
                       link_pc, rY, vY, dmem_ren, dmem_wen);

    modport mem (input valid, halt, rf_wen, wb_op, rO, alu_out, flag,
                       link_pc, rY, vY, dmem_ren, dmem_wen);
endinterface

// ************************************************************************
// Memory to writeback
// ************************************************************************
interface mem_wb_if ();
    logic                   valid;
    logic                   halt;
    logic                   rf_wen;
    logic [`CPU_REG_AW-1:0] rO;
    logic [`CPU_DATA_W-1:0] wb_data;   // Final selected value.

    modport source  (output valid, halt, rf_wen, rO, wb_data);
    modport sink    (input  valid, halt, rf_wen, rO, wb_data);
    modport monitor (input  valid, halt, rf_wen, rO, wb_data);
endinterface

`default_nettype wire
